/* design/rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

	localparam int xlen = 32;
	localparam int regCount = 32;
	localparam int regBits = 5;
	localparam int dmemWords = 256;
	localparam int dmemIndexBits = $clog2(dmemWords);
	localparam logic [xlen-1:0] resetPc = '0;

	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opOpImm = 7'b0010011;
	localparam logic [6:0] opOp = 7'b0110011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opSystem = 7'b1110011;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSll, aluSrl, aluSra, aluSlt, aluSltu, aluPassB
	} aluOp_t;

	typedef enum logic [1:0] {wbAlu, wbLoad, wbPcPlus4, wbNone} wbSel_t;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} memSize_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} riView_t;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sbView_t;

	typedef union packed {
		riView_t ri;
		sbView_t sb;
	} instWord_u;

endpackage

`default_nettype wire

/* design/pipeIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface decExIf
	import rvCorePkg::*;
();
	logic valid;
	logic ready;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;
	logic [xlen-1:0] storeData;
	logic [xlen-1:0] imm;
	aluOp_t aluOp;
	wbSel_t wbSel;
	logic [regBits-1:0] rd;
	logic regWrite;
	logic memRead;
	logic memWrite;
	memSize_t memSize;
	logic memSigned;
	logic isBranch;
	logic branchOnEqual;
	logic isJal;

	modport producer (
		output valid, pc, opA, opB, storeData, imm, aluOp, wbSel, rd, regWrite,
		output memRead, memWrite, memSize, memSigned, isBranch, branchOnEqual, isJal,
		input ready
	);
	modport consumer (
		input valid, pc, opA, opB, storeData, imm, aluOp, wbSel, rd, regWrite,
		input memRead, memWrite, memSize, memSigned, isBranch, branchOnEqual, isJal,
		output ready
	);
endinterface

interface exMemIf
	import rvCorePkg::*;
();
	logic valid;
	logic ready;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] aluResult;
	logic [xlen-1:0] storeData;
	logic [regBits-1:0] rd;
	logic regWrite;
	wbSel_t wbSel;
	logic memRead;
	logic memWrite;
	memSize_t memSize;
	logic memSigned;

	modport producer (
		output valid, pc, aluResult, storeData, rd, regWrite, wbSel,
		output memRead, memWrite, memSize, memSigned,
		input ready
	);
	modport consumer (
		input valid, pc, aluResult, storeData, rd, regWrite, wbSel,
		input memRead, memWrite, memSize, memSigned,
		output ready
	);
endinterface

`default_nettype wire

/* design/registerFile.sv */
`timescale 1ns/10ps
`default_nettype none

module registerFile
	import rvCorePkg::*;
(
	input wire clk,
	input wire rstN,
	input wire [regBits-1:0] readIndexA,
	input wire [regBits-1:0] readIndexB,
	output logic [xlen-1:0] readDataA,
	output logic [xlen-1:0] readDataB,
	input wire writeEnable,
	input wire [regBits-1:0] writeIndex,
	input wire [xlen-1:0] writeData
);

	logic [xlen-1:0] regs [regCount];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeIndex] <= writeData;
		end
	end

	// write bypass lets decode see the retiring value
	assign readDataA = (readIndexA == '0) ? '0
		: (writeEnable && writeIndex == readIndexA) ? writeData : regs[readIndexA];
	assign readDataB = (readIndexB == '0) ? '0
		: (writeEnable && writeIndex == readIndexB) ? writeData : regs[readIndexB];

	noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
		writeEnable |-> writeIndex != '0);

endmodule

`default_nettype wire

/* design/fetchStage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchStage
	import rvCorePkg::*;
(
	input wire clk,
	input wire rstN,
	output logic [xlen-1:0] pc,
	input wire instValid,
	output logic instReady,
	input wire [xlen-1:0] inst,
	input wire redirect,
	input wire [xlen-1:0] redirectTarget,
	input wire decodeFree,
	input wire halt,
	output logic fetchValid,
	output logic [xlen-1:0] fetchWord,
	output logic [xlen-1:0] fetchPc
);

	logic running;
	logic haltLatch;
	logic accept;

	assign instReady = running && !haltLatch && !halt && decodeFree;
	assign accept = instValid && instReady;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			running <= 1'b0;
			haltLatch <= 1'b0;
			pc <= resetPc;
			fetchValid <= 1'b0;
		end else begin
			running <= 1'b1;
			haltLatch <= haltLatch || halt;
			// redirect wins over a word accepted in the same cycle
			if (redirect) begin
				pc <= redirectTarget;
				fetchValid <= 1'b0;
			end else if (accept) begin
				pc <= pc + xlen'(4);
				fetchValid <= 1'b1;
			end else if (decodeFree) begin
				fetchValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			fetchWord <= inst;
			fetchPc <= pc;
		end
	end

	// targets come from execute, so this checks the whole redirect path
	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStage
	import rvCorePkg::*;
(
	input wire clk,
	input wire rstN,
	input wire fetchValid,
	input wire [xlen-1:0] fetchWord,
	input wire [xlen-1:0] fetchPc,
	output logic decodeFree,
	output logic [regBits-1:0] readIndexA,
	output logic [regBits-1:0] readIndexB,
	input wire [xlen-1:0] readDataA,
	input wire [xlen-1:0] readDataB,
	input wire flush,
	input wire [regBits-1:0] busyRdEx,
	input wire [regBits-1:0] busyRdMem,
	output logic halt,
	decExIf.producer dx
);

	instWord_u word;
	logic [xlen-1:0] imm;
	logic useImm, useRs1, useRs2, isEbreak;
	logic regWrite, memRead, memWrite, isBranch, isJal;
	logic hazardA, hazardB, stall, load;
	aluOp_t aluOp;
	wbSel_t wbSel;

	function automatic aluOp_t aluDecode(input logic [2:0] f3, input logic alt,
			input logic isReg);
		case (f3)
			3'b000: return (isReg && alt) ? aluSub : aluAdd;
			3'b001: return aluSll;
			3'b010: return aluSlt;
			3'b011: return aluSltu;
			3'b100: return aluXor;
			3'b101: return alt ? aluSra : aluSrl;
			3'b110: return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	assign word = fetchWord;
	assign readIndexA = word.ri.rs1;
	assign readIndexB = word.ri.rs2;

	always_comb begin
		// I-type immediate unless the opcode says otherwise
		imm = {{20{word.ri.funct7[6]}}, word.ri.funct7, word.ri.rs2};
		useImm = 1'b0;
		useRs1 = 1'b1;
		useRs2 = 1'b0;
		aluOp = aluAdd;
		wbSel = wbNone;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		isBranch = 1'b0;
		isJal = 1'b0;
		isEbreak = 1'b0;
		case (word.ri.opcode)
			opOp: begin
				useRs2 = 1'b1;
				regWrite = 1'b1;
				wbSel = wbAlu;
				aluOp = aluDecode(word.ri.funct3, word.ri.funct7[5], 1'b1);
			end
			opOpImm: begin
				useImm = 1'b1;
				regWrite = 1'b1;
				wbSel = wbAlu;
				aluOp = aluDecode(word.ri.funct3, word.ri.funct7[5], 1'b0);
			end
			opLoad: begin
				useImm = 1'b1;
				regWrite = 1'b1;
				wbSel = wbLoad;
				memRead = 1'b1;
			end
			opStore: begin
				useRs2 = 1'b1;
				useImm = 1'b1;
				memWrite = 1'b1;
				imm = {{20{word.sb.immHi[6]}}, word.sb.immHi, word.sb.immLo};
			end
			opBranch: begin
				useRs2 = 1'b1;
				aluOp = aluSub;
				isBranch = 1'b1;
				imm = {{20{word.sb.immHi[6]}}, word.sb.immLo[0], word.sb.immHi[5:0],
					word.sb.immLo[4:1], 1'b0};
			end
			opJal: begin
				useRs1 = 1'b0;
				isJal = 1'b1;
				regWrite = 1'b1;
				wbSel = wbPcPlus4;
				imm = {{12{word.ri.funct7[6]}}, word.ri.rs1, word.ri.funct3, word.ri.rs2[0],
					word.ri.funct7[5:0], word.ri.rs2[4:1], 1'b0};
			end
			opLui: begin
				useRs1 = 1'b0;
				useImm = 1'b1;
				regWrite = 1'b1;
				wbSel = wbAlu;
				aluOp = aluPassB;
				imm = {word.ri.funct7, word.ri.rs2, word.ri.rs1, word.ri.funct3, 12'b0};
			end
			opSystem: begin
				useRs1 = 1'b0;
				isEbreak = 1'b1;
			end
			default: useRs1 = 1'b0;
		endcase
	end

	// busy indexes read zero when nothing is writing
	assign hazardA = useRs1 && word.ri.rs1 != '0
		&& (word.ri.rs1 == busyRdEx || word.ri.rs1 == busyRdMem);
	assign hazardB = useRs2 && word.ri.rs2 != '0
		&& (word.ri.rs2 == busyRdEx || word.ri.rs2 == busyRdMem);
	assign stall = fetchValid && (hazardA || hazardB);

	assign halt = fetchValid && isEbreak && !flush;
	assign load = fetchValid && !stall && !flush && !isEbreak && (!dx.valid || dx.ready);
	assign decodeFree = !fetchValid || load;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dx.valid <= 1'b0;
		end else if (load) begin
			dx.valid <= 1'b1;
		end else if (dx.ready) begin
			dx.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			dx.pc <= fetchPc;
			dx.opA <= readDataA;
			dx.opB <= useImm ? imm : readDataB;
			dx.storeData <= readDataB;
			dx.imm <= imm;
			dx.aluOp <= aluOp;
			dx.wbSel <= wbSel;
			dx.rd <= word.ri.rd;
			dx.regWrite <= regWrite;
			dx.memRead <= memRead;
			dx.memWrite <= memWrite;
			dx.memSize <= memSize_t'(word.ri.funct3[1:0]);
			dx.memSigned <= !word.ri.funct3[2];
			dx.isBranch <= isBranch;
			dx.branchOnEqual <= !word.ri.funct3[0];
			dx.isJal <= isJal;
		end
	end

	// a stalled word stays put in the fetch holding register
	stallHolds: assert property (@(posedge clk) disable iff (!rstN)
		(stall && !flush) |=> (fetchValid && fetchPc == $past(fetchPc)));

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module executeStage
	import rvCorePkg::*;
(
	input wire clk,
	input wire rstN,
	decExIf.consumer dx,
	exMemIf.producer em,
	output logic redirect,
	output logic [xlen-1:0] redirectTarget,
	output logic [regBits-1:0] busyRdEx
);

	logic [xlen-1:0] aluResult;
	logic zero;
	logic taken;
	logic take;

	always_comb begin
		case (dx.aluOp)
			aluAdd: aluResult = dx.opA + dx.opB;
			aluSub: aluResult = dx.opA - dx.opB;
			aluAnd: aluResult = dx.opA & dx.opB;
			aluOr: aluResult = dx.opA | dx.opB;
			aluXor: aluResult = dx.opA ^ dx.opB;
			aluSll: aluResult = dx.opA << dx.opB[4:0];
			aluSrl: aluResult = dx.opA >> dx.opB[4:0];
			aluSra: aluResult = $signed(dx.opA) >>> dx.opB[4:0];
			aluSlt: aluResult = {31'b0, $signed(dx.opA) < $signed(dx.opB)};
			aluSltu: aluResult = {31'b0, dx.opA < dx.opB};
			default: aluResult = dx.opB;
		endcase
	end

	assign zero = aluResult == '0;
	// BEQ takes on zero, BNE on nonzero
	assign taken = dx.isJal || (dx.isBranch && (zero == dx.branchOnEqual));

	assign dx.ready = !em.valid || em.ready;
	assign take = dx.valid && dx.ready;

	assign redirect = take && taken;
	assign redirectTarget = dx.pc + dx.imm;
	assign busyRdEx = (dx.valid && dx.regWrite) ? dx.rd : '0;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			em.valid <= 1'b0;
		end else if (take) begin
			em.valid <= 1'b1;
		end else if (em.ready) begin
			em.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			em.pc <= dx.pc;
			em.aluResult <= aluResult;
			em.storeData <= dx.storeData;
			em.rd <= dx.rd;
			em.regWrite <= dx.regWrite;
			em.wbSel <= dx.wbSel;
			em.memRead <= dx.memRead;
			em.memWrite <= dx.memWrite;
			em.memSize <= dx.memSize;
			em.memSigned <= dx.memSigned;
		end
	end

endmodule

`default_nettype wire

/* design/memoryStage.sv */
`timescale 1ns/10ps
`default_nettype none

module memoryStage
	import rvCorePkg::*;
(
	input wire clk,
	input wire rstN,
	exMemIf.consumer em,
	output logic [regBits-1:0] busyRdMem,
	output logic writeEnable,
	output logic [regBits-1:0] writeIndex,
	output logic [xlen-1:0] writeData,
	output logic retireValid,
	output logic [xlen-1:0] retirePc,
	output logic [regBits-1:0] retireRd,
	output logic [xlen-1:0] retireData
);

	logic [xlen-1:0] dataMem [dmemWords];
	logic [dmemIndexBits-1:0] index;
	logic [3:0] laneEnable;
	logic [xlen-1:0] laneData;
	logic [xlen-1:0] readWord, shifted, loadValue, wbValue;
	logic [xlen-1:0] retAlu;
	logic [regBits-1:0] retRd;
	logic [1:0] retOffset;
	logic retRegWrite, retStore, retSigned;
	wbSel_t retWbSel;
	memSize_t retSize;

	assign em.ready = 1'b1;
	assign busyRdMem = (em.valid && em.regWrite) ? em.rd : '0;
	assign index = em.aluResult[dmemIndexBits+1:2];

	always_comb begin
		case (em.memSize)
			sizeByte: begin
				laneEnable = 4'b0001 << em.aluResult[1:0];
				laneData = {4{em.storeData[7:0]}};
			end
			sizeHalf: begin
				laneEnable = 4'b0011 << em.aluResult[1:0];
				laneData = {2{em.storeData[15:0]}};
			end
			default: begin
				laneEnable = 4'b1111;
				laneData = em.storeData;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (em.valid && em.memWrite) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (laneEnable[lane]) begin
					dataMem[index][lane*8 +: 8] <= laneData[lane*8 +: 8];
				end
			end
		end
		if (em.valid && em.memRead) begin
			readWord <= dataMem[index];
		end
		if (em.valid) begin
			retirePc <= em.pc;
			retAlu <= em.aluResult;
			retRd <= em.rd;
			retRegWrite <= em.regWrite;
			retStore <= em.memWrite;
			retWbSel <= em.wbSel;
			retSize <= em.memSize;
			retSigned <= em.memSigned;
			retOffset <= em.aluResult[1:0];
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			retireValid <= 1'b0;
		end else begin
			retireValid <= em.valid;
		end
	end

	assign shifted = readWord >> {retOffset, 3'b000};

	always_comb begin
		case (retSize)
			sizeByte: loadValue = {{24{retSigned && shifted[7]}}, shifted[7:0]};
			sizeHalf: loadValue = {{16{retSigned && shifted[15]}}, shifted[15:0]};
			default: loadValue = shifted;
		endcase
		case (retWbSel)
			wbAlu: wbValue = retAlu;
			wbLoad: wbValue = loadValue;
			wbPcPlus4: wbValue = retirePc + xlen'(4);
			// stores show their address
			default: wbValue = retStore ? retAlu : '0;
		endcase
	end

	assign writeEnable = retireValid && retRegWrite && retRd != '0;
	assign writeIndex = retRd;
	assign writeData = wbValue;
	assign retireRd = retRegWrite ? retRd : '0;
	assign retireData = wbValue;

	halfAligned: assert property (@(posedge clk) disable iff (!rstN)
		(em.valid && (em.memRead || em.memWrite) && em.memSize == sizeHalf)
		|-> !em.aluResult[0]);

endmodule

`default_nettype wire

/* design/rvCore.sv */
`timescale 1ns/10ps
`default_nettype none

module rvCore
	import rvCorePkg::*;
(
	input wire clk,
	input wire rstN,
	output logic [xlen-1:0] pc,
	input wire instValid,
	output logic instReady,
	input wire [xlen-1:0] inst,
	output logic retireValid,
	output logic [xlen-1:0] retirePc,
	output logic [regBits-1:0] retireRd,
	output logic [xlen-1:0] retireData,
	output logic halted
);

	logic decodeFree, redirect, fetchValid, writeEnable;
	logic [xlen-1:0] redirectTarget, fetchWord, fetchPc;
	logic [xlen-1:0] readDataA, readDataB, writeData;
	logic [regBits-1:0] readIndexA, readIndexB, writeIndex;
	logic [regBits-1:0] busyRdEx, busyRdMem;

	decExIf dx ();
	exMemIf em ();

	fetchStage i_fetchStage (
		.clk(clk), .rstN(rstN), .pc(pc), .instValid(instValid), .instReady(instReady),
		.inst(inst), .redirect(redirect), .redirectTarget(redirectTarget),
		.decodeFree(decodeFree), .halt(halted), .fetchValid(fetchValid),
		.fetchWord(fetchWord), .fetchPc(fetchPc)
	);

	decodeStage i_decodeStage (
		.clk(clk), .rstN(rstN), .fetchValid(fetchValid), .fetchWord(fetchWord),
		.fetchPc(fetchPc), .decodeFree(decodeFree), .readIndexA(readIndexA),
		.readIndexB(readIndexB), .readDataA(readDataA), .readDataB(readDataB),
		.flush(redirect), .busyRdEx(busyRdEx), .busyRdMem(busyRdMem), .halt(halted),
		.dx(dx.producer)
	);

	registerFile i_registerFile (
		.clk(clk), .rstN(rstN), .readIndexA(readIndexA), .readIndexB(readIndexB),
		.readDataA(readDataA), .readDataB(readDataB), .writeEnable(writeEnable),
		.writeIndex(writeIndex), .writeData(writeData)
	);

	executeStage i_executeStage (
		.clk(clk), .rstN(rstN), .dx(dx.consumer), .em(em.producer), .redirect(redirect),
		.redirectTarget(redirectTarget), .busyRdEx(busyRdEx)
	);

	memoryStage i_memoryStage (
		.clk(clk), .rstN(rstN), .em(em.consumer), .busyRdMem(busyRdMem),
		.writeEnable(writeEnable), .writeIndex(writeIndex), .writeData(writeData),
		.retireValid(retireValid), .retirePc(retirePc), .retireRd(retireRd),
		.retireData(retireData)
	);

endmodule

`default_nettype wire

/* verification/rvCoreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module rvCoreTb
	import rvCorePkg::*;
();

	localparam int imageWords = 256;
	localparam int countAddr = 'h40;
	localparam int recordBase = 'h41;
	localparam int resetCycles = 16;
	localparam int cyclesPerRetire = 20;
	localparam int drainCycles = 8;

	logic clk;
	logic rstN;
	logic [xlen-1:0] pc;
	logic instValid;
	logic instReady;
	logic [xlen-1:0] inst;
	logic retireValid;
	logic [xlen-1:0] retirePc;
	logic [regBits-1:0] retireRd;
	logic [xlen-1:0] retireData;
	logic halted;

	// program words at the bottom, retire records from countAddr up
	logic [31:0] image [imageWords];
	int expCount;
	int retired;

	rvCore i_rvCore (
		.clk(clk),
		.rstN(rstN),
		.pc(pc),
		.instValid(instValid),
		.instReady(instReady),
		.inst(inst),
		.retireValid(retireValid),
		.retirePc(retirePc),
		.retireRd(retireRd),
		.retireData(retireData),
		.halted(halted)
	);

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	// compares one retirement with the next record
	task automatic checkRetire();
		int idx;
		logic [xlen-1:0] expPc;
		logic [regBits-1:0] expRd;
		logic [xlen-1:0] expData;
		assert (retired < expCount) else begin
			abortRun($sformatf("instruction at pc %h retired after the last expected one",
				retirePc));
		end
		idx = recordBase + 3 * retired;
		expPc = image[idx];
		expRd = image[idx + 1][regBits-1:0];
		expData = image[idx + 2];
		assert (retirePc == expPc) else begin
			abortRun($sformatf("Error at time %0t: retirePc expected %h, actual %h",
				$time, expPc, retirePc));
		end
		assert (retireRd == expRd) else begin
			abortRun($sformatf("Error at time %0t: retireRd expected %0d, actual %0d",
				$time, expRd, retireRd));
		end
		assert (retireData == expData) else begin
			abortRun($sformatf("Error at time %0t: retireData expected %h, actual %h",
				$time, expData, retireData));
		end
		retired++;
	endtask

	// no word may be requested in reset or once halted
	task automatic checkNoRequest();
		assert (instReady == 1'b0) else begin
			abortRun($sformatf("Error at time %0t: instReady expected 0, actual %b",
				$time, instReady));
		end
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// instruction memory answers the current pc
	always @(pc or rstN) begin
		inst <= image[{2'b00, pc[7:2]}];
	end

	// roughly one cycle in four without a word
	always @(posedge clk) begin
		if (rstN) begin
			instValid <= $urandom_range(3) != 0;
		end
	end

	always @(posedge clk) begin
		if (rstN && retireValid) begin
			checkRetire();
		end
	end

	initial begin
		rstN = 1'b0;
		instValid = 1'b0;
		inst = '0;
		retired = 0;
		void'($urandom(32'h84ff));
		$readmemh("verification/programInput.txt", image);
		expCount = int'(image[countAddr]);
		repeat (resetCycles) @(posedge clk);
		// pc starts from address zero
		assert (pc == '0) else begin
			abortRun($sformatf("Error at time %0t: pc expected %h, actual %h",
				$time, 32'h0, pc));
		end
		checkNoRequest();
		rstN <= 1'b1;
		wait (halted === 1'b1);
		// older instructions drain, nothing younger may follow
		repeat (drainCycles) @(posedge clk);
		checkNoRequest();
		if (retired == expCount && halted) begin
			$display("TEST OK");
			$finish;
		end else begin
			abortRun($sformatf("core halted after %0d of %0d expected retirements",
				retired, expCount));
		end
	end

	initial begin
		#1;
		repeat (resetCycles + cyclesPerRetire * expCount) @(posedge clk);
		abortRun("timeout: the core did not halt with every expected instruction retired");
	end

endmodule

`default_nettype wire

/* verification/programInput.txt */
// program words from @00, four per line
// @40 holds the retirement count, then one record per line: pc rd data
@00
00500093 ffd08113 002081b3 40110233 // addi x1, dependent addi x2, add x3, sub x4
123452b7 0032e333 00409393 40225433 // lui x5, or x6, slli x7, sra x8
0040b4b3 00708013 00100533 8765f5b7 // sltu x9, addi x0, add x10 from x0, lui x11
0a158593 00b02823 01000603 01104683 // addi x11, sw 16, lb 16, lbu 17
01201703 01005783 001009a3 00701823 // lh 18, lhu 16, sb 19, sh 16
01002803 00a08463 00100893 00209463 // lw 16, beq taken, skipped, bne taken
00200893 00208463 00300893 00c0096f // skipped, beq not taken, addi x17, jal x18
00400893 00500893 011909b3 00100073 // skipped, skipped, add x19, ebreak
00600a13                            // after ebreak, never retires
@40
0000001b
00000000 01 00000005
00000004 02 00000002
00000008 03 00000007
0000000c 04 fffffffd
00000010 05 12345000
00000014 06 12345007
00000018 07 00000050
0000001c 08 ffffffff
00000020 09 00000001
00000024 00 0000000c
00000028 0a 00000005
0000002c 0b 8765f000
00000030 0b 8765f0a1
00000034 00 00000010
00000038 0c ffffffa1
0000003c 0d 000000f0
00000040 0e ffff8765
00000044 0f 0000f0a1
00000048 00 00000013
0000004c 00 00000010
00000050 10 05650050
00000054 00 00000000
0000005c 00 00000000
00000064 00 00000000
00000068 11 00000003
0000006c 12 00000070
00000078 13 00000073

/* compile.f */
design/rvCorePkg.sv
design/pipeIf.sv
design/registerFile.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/rvCore.sv
verification/rvCoreTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module rvCoreTb \
	&& ./obj_dir/VrvCoreTb || exit 1
